// File: dv/tf_tb.sv
`timescale 1ns/1ps

module tf_tb;
   import tf_bus_pkg::*;
   import tf_flag_pkg::*;

   localparam int wait_max = 200;  // cycles allowed for any single wait

   logic                   clk;
   logic                   rst;
   logic                   req;
   logic                   we;
   logic [bus_addr_w-1:0]  addr;
   logic [bus_data_w-1:0]  wdata;
   logic                   ack;
   logic [bus_data_w-1:0]  rdata;
   logic                   in_valid;
   logic [flag_data_w-1:0] in_data;
   logic                   match;
   logic                   done_req;
   logic                   done_ack;
   logic [count_w-1:0]     done_cycles;

   integer                 seed = 32'hed8f_4e9c;
   logic [flag_data_w-1:0] pat [8];
   int                     errors;
   int                     checks;
   int                     cyc;
   int                     ack_cyc;     // cycle of the last bus ack
   int                     match_cyc;   // cycle of the last match seen by stream_word
   int                     pulses;
   logic [31:0]            rd;
   logic                   seen;

   timed_flag_top timed_flag_top_i (
      .clk(clk), .rst(rst), .req(req), .we(we), .addr(addr), .wdata(wdata),
      .ack(ack), .rdata(rdata), .in_valid(in_valid), .in_data(in_data),
      .match(match), .done_req(done_req), .done_ack(done_ack),
      .done_cycles(done_cycles)
   );

   always #10 clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   always @(negedge clk) begin
      if (match) pulses++;  // match is combinational, stable mid cycle
   end

   task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR t=%0t %s: got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   // four-phase access, entered and left 1 ns after a rising edge
   task automatic bus_access(input logic wr, input logic [bus_addr_w-1:0] a,
                             input logic [31:0] d, output logic [31:0] q);
      int n;
      req = 1'b1;
      we = wr;
      addr = a;
      wdata = d;
      q = '0;
      for (n = 0; n < wait_max && !ack; n++) begin
         @(posedge clk);
         #1;
      end
      if (!ack) begin
         errors++;
         $display("bus access to %0h got no ack, gave up at %0t", a, $time);
      end
      ack_cyc = cyc;
      q = rdata;
      req = 1'b0;
      for (n = 0; n < wait_max && ack; n++) begin
         @(posedge clk);
         #1;
      end
      if (ack) begin
         errors++;
         $display("ack stayed high after req dropped, gave up at %0t", $time);
      end
   endtask

   task automatic bus_write(input logic [bus_addr_w-1:0] a, input logic [31:0] d);
      logic [31:0] unused;
      bus_access(1'b1, a, d, unused);
   endtask

   task automatic bus_read(input logic [bus_addr_w-1:0] a, output logic [31:0] q);
      bus_access(1'b0, a, '0, q);
   endtask

   // hold one word on the stream until the unit flags it or max_cyc runs out
   task automatic stream_word(input logic [flag_data_w-1:0] w, input int max_cyc,
                              output logic got);
      int n;
      got = 1'b0;
      in_valid = 1'b1;
      in_data = w;
      for (n = 0; n < max_cyc && !got; n++) begin
         @(negedge clk);
         if (match) begin
            got = 1'b1;
            match_cyc = cyc;
         end
         @(posedge clk);
         #1;
      end
      in_valid = 1'b0;
   endtask

   task automatic wait_done_req();
      int n;
      for (n = 0; n < wait_max && !done_req; n++) begin
         @(posedge clk);
         #1;
      end
      if (!done_req) begin
         errors++;
         $display("done_req never rose, gave up at %0t", $time);
      end
      done_ack = 1'b1;
      for (n = 0; n < wait_max && done_req; n++) begin
         @(posedge clk);
         #1;
      end
      if (done_req) begin
         errors++;
         $display("done_req stuck high after done_ack at %0t", $time);
      end
      done_ack = 1'b0;
      @(posedge clk);
      #1;
   endtask

   task automatic start_run(input int amount, input int delay);
      bus_write(reg_amount, amount);
      bus_write(reg_delay, delay);
      bus_write(reg_ctrl, 32'h1);
   endtask

   task automatic end_test(input string name, input int err_before);
      $display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
   endtask

   task automatic test_reset_regs();
      int e0 = errors;
      check(done_req, 0, "done_req after reset");
      check(match, 0, "match after reset");
      bus_read(reg_status, rd);
      check(rd[0], 1, "status done after reset");
      bus_read(reg_count, rd);
      check(rd, 0, "count after reset");
      bus_write(reg_amount, 32'd5);
      bus_write(reg_delay, 32'd7);
      bus_write(reg_ctrl, 32'h2);
      bus_read(reg_amount, rd);
      check(rd, 5, "amount readback");
      bus_read(reg_delay, rd);
      check(rd, 7, "delay readback");
      bus_read(reg_ctrl, rd);
      check(rd, 2, "ctrl readback");
      bus_write(reg_ctrl, 32'h0);
      end_test("reset_regs", e0);
   endtask

   task automatic test_basic_run();
      int e0 = errors;
      for (int i = 0; i < 8; i++) begin
         pat[i] = $random(seed);
         bus_write(pat_base + i, pat[i]);
      end
      pulses = 0;
      start_run(8, 0);
      bus_read(reg_status, rd);
      check(rd[0], 0, "status busy after run");
      for (int i = 0; i < 8; i++) begin
         stream_word(pat[i], 40, seen);
         check(seen, 1, $sformatf("match on word %0d", i));
      end
      check(pulses, 8, "match pulses");
      wait_done_req();
      bus_read(reg_status, rd);
      check(rd[0], 1, "status done");
      bus_read(reg_count, rd);
      check(rd, 8, "count");
      end_test("basic_run", e0);
   endtask

   task automatic test_mismatch();
      int e0 = errors;
      pulses = 0;
      start_run(8, 0);
      for (int i = 0; i < 8; i++) begin
         stream_word(~pat[i], 4, seen);
         check(seen, 0, $sformatf("no match on wrong word before %0d", i));
         stream_word(pat[i], 40, seen);
         check(seen, 1, $sformatf("match on word %0d", i));
      end
      check(pulses, 8, "match pulses");
      wait_done_req();
      bus_read(reg_count, rd);
      check(rd, 8, "count");
      end_test("mismatch", e0);
   endtask

   task automatic test_start_delay();
      int e0 = errors;
      int run_ack;
      start_run(2, 20);
      run_ack = ack_cyc;
      stream_word(pat[0], 60, seen);
      check(seen, 1, "match after delay");
      // run issues one cycle after the ctrl ack, then 20 idle cycles
      check((match_cyc - run_ack) >= 21, 1, "no match inside start delay");
      stream_word(pat[1], 40, seen);
      check(seen, 1, "second match");
      wait_done_req();
      check(done_cycles >= 22, 1, "done_cycles covers delay and amount");
      end_test("start_delay", e0);
   endtask

   task automatic test_disabled();
      int e0 = errors;
      int n;
      start_run(0, 0);  // empty run clears the match count
      bus_read(reg_count, rd);
      check(rd, 0, "count cleared");
      bus_write(reg_amount, 32'd4);  // an enabled run would now count
      pulses = 0;
      bus_write(reg_ctrl, 32'h3);
      bus_read(reg_count, rd);
      check(rd, 0, "count while disabled");
      bus_read(reg_status, rd);
      check(rd[0], 1, "done unchanged");
      stream_word(pat[0], 10, seen);
      check(seen, 0, "no match while disabled");
      for (n = 0; n < 30 && !done_req; n++) begin
         @(posedge clk);
         #1;
      end
      check(done_req, 0, "done_req while disabled");
      check(pulses, 0, "match pulses");
      bus_write(reg_ctrl, 32'h0);
      end_test("disabled", e0);
   endtask

   task automatic test_rerun();
      int e0 = errors;
      pulses = 0;
      start_run(3, 0);
      for (int i = 0; i < 3; i++) begin
         stream_word(pat[i], 40, seen);
         check(seen, 1, $sformatf("match on word %0d", i));
      end
      wait_done_req();
      stream_word(pat[3], 8, seen);
      check(seen, 0, "no match after amount reached");
      check(pulses, 3, "match pulses first run");
      start_run(2, 0);
      for (int i = 0; i < 2; i++) begin
         stream_word(pat[i], 40, seen);
         check(seen, 1, $sformatf("rerun match on word %0d", i));
      end
      wait_done_req();
      bus_read(reg_count, rd);
      check(rd, 2, "count second run");
      end_test("rerun", e0);
   endtask

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      req = 1'b0;
      we = 1'b0;
      addr = '0;
      wdata = '0;
      in_valid = 1'b0;
      in_data = '0;
      done_ack = 1'b0;
      errors = 0;
      checks = 0;
      cyc = 0;
      pulses = 0;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      @(posedge clk);
      #1;
      test_reset_regs();
      test_basic_run();
      test_mismatch();
      test_start_delay();
      test_disabled();
      test_rerun();
      $display("tests 6 checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: hw/tf_bus_pkg.sv
package tf_bus_pkg;

   // host bus geometry, word addressed
   localparam int bus_addr_w = 10;
   localparam int bus_data_w = 32;

   // pattern memory depth is 2**pat_addr_w words
   localparam int pat_addr_w = 8;

   // register offsets in the lower half of the address space
   localparam logic [bus_addr_w-1:0] reg_amount = 10'h000;  // matches to see
   localparam logic [bus_addr_w-1:0] reg_delay  = 10'h001;  // start delay in cycles
   localparam logic [bus_addr_w-1:0] reg_ctrl   = 10'h002;  // bit 0 run, bit 1 disable
   localparam logic [bus_addr_w-1:0] reg_status = 10'h003;  // bit 0 done
   localparam logic [bus_addr_w-1:0] reg_count  = 10'h004;  // matches seen since run

   // top address bit set selects the pattern memory
   localparam logic [bus_addr_w-1:0] pat_base = 10'h200;

endpackage

// File: hw/tf_done_report.sv
`timescale 1ns/1ps

module tf_done_report (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            run,
   input  logic                            done,
   input  logic                            done_ack,
   output logic                            done_req,
   output logic [tf_flag_pkg::count_w-1:0] done_cycles
);
   import tf_flag_pkg::*;

   typedef enum logic [1:0] {
      hs_idle,
      hs_req,
      hs_release
   } hs_state_t;

   hs_state_t          hs_state;
   logic [count_w-1:0] elapsed;
   logic               timing;   // between run and done
   logic               pending;  // finished, report not yet sent
   logic               done_q;
   logic               done_rise;

   assign done_rise = done && !done_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_q  <= 1'b1;  // done is high out of reset
         timing  <= 1'b0;
         pending <= 1'b0;
         elapsed <= '0;
      end else begin
         done_q <= done;
         if (run) begin
            timing  <= 1'b1;
            pending <= 1'b0;
            elapsed <= '0;
         end else if (timing) begin
            elapsed <= elapsed + 1'b1;
            if (done_rise) begin
               timing  <= 1'b0;  // elapsed freezes here
               pending <= 1'b1;
            end
         end else if (pending && hs_state == hs_idle) begin
            pending <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         hs_state <= hs_idle;
      end else begin
         case (hs_state)
            hs_idle:    if (pending && !run) hs_state <= hs_req;
            hs_req:     if (done_ack) hs_state <= hs_release;
            hs_release: if (!done_ack) hs_state <= hs_idle;
            default:    hs_state <= hs_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (hs_state == hs_idle && pending && !run) begin
         done_cycles <= elapsed;
      end
   end

   assign done_req = (hs_state == hs_req);

   // the host acknowledges before the request goes away
   a_req_held: assert property (@(posedge clk) disable iff (rst)
      $fell(done_req) |-> $past(done_ack));

endmodule

// File: hw/tf_flag_pkg.sv
package tf_flag_pkg;

   // width of a stream word and of a pattern word
   localparam int flag_data_w = 32;

   // amount, delay, remaining and elapsed cycle counters
   localparam int count_w = 32;

endpackage

// File: hw/tf_match_exec.sv
`timescale 1ns/1ps

module tf_match_exec #(
   parameter int data_w = tf_flag_pkg::flag_data_w
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            run,
   input  logic                            disabled,
   input  logic [tf_flag_pkg::count_w-1:0] amount,
   input  logic [tf_flag_pkg::count_w-1:0] delay0,
   input  logic                            in_valid,
   input  logic [data_w-1:0]               in_data,
   input  logic [data_w-1:0]               current_value,
   input  logic                            wait_busy,
   output logic                            advance,
   output logic                            match,
   output logic                            done,
   output logic [tf_flag_pkg::count_w-1:0] match_count
);
   import tf_flag_pkg::*;

   logic [count_w-1:0] delay_cnt;
   logic [count_w-1:0] remaining;
   logic               armed;
   logic               start;

   assign start = run && !disabled;

   // listening once the start delay is over and matches are still owed
   assign armed = !run && !disabled && (delay_cnt == '0) && (remaining != '0);

   assign advance = armed && !wait_busy && in_valid && (in_data == current_value);
   assign match   = advance;  // flag follows each counted match
   assign done    = (remaining == '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         delay_cnt   <= '0;
         remaining   <= '0;
         match_count <= '0;
      end else if (start) begin
         delay_cnt   <= delay0;
         remaining   <= amount;
         match_count <= '0;
      end else begin
         if (delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
         end
         if (advance) begin
            remaining   <= remaining - 1'b1;
            match_count <= match_count + 1'b1;
         end
      end
   end

   // once exhausted, remaining only moves again through a new run
   a_no_underflow: assert property (@(posedge clk) disable iff (rst)
      (remaining == '0) && !start |=> (remaining == '0));

endmodule

// File: hw/tf_memory_scanner.sv
`timescale 1ns/1ps

module tf_memory_scanner #(
   parameter int mem_addr_w = tf_bus_pkg::pat_addr_w
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  restart,
   input  logic                  advance,
   output logic [mem_addr_w-1:0] rd_addr,
   output logic                  wait_busy
);

   logic [1:0] settle_cnt;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_addr <= '0;
      end else if (restart) begin
         rd_addr <= '0;
      end else if (advance) begin
         rd_addr <= rd_addr + 1'b1;  // no wrap handling, pattern is short
      end
   end

   // hold off while the registered read catches up with the new address
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         settle_cnt <= 2'd0;
      end else if (restart || advance) begin
         settle_cnt <= 2'd2;
      end else if (settle_cnt != 2'd0) begin
         settle_cnt <= settle_cnt - 2'd1;
      end
   end

   assign wait_busy = (settle_cnt != 2'd0);

   // the match engine must not count against a stale pattern word
   a_no_advance_busy: assert property (@(posedge clk) disable iff (rst)
      advance |-> !wait_busy);

endmodule

// File: hw/tf_pattern_ram.sv
`timescale 1ns/1ps

module tf_pattern_ram #(
   parameter int data_w     = tf_flag_pkg::flag_data_w,
   parameter int mem_addr_w = tf_bus_pkg::pat_addr_w
) (
   input  logic                  clk,
   input  logic                  we,
   input  logic [mem_addr_w-1:0] waddr,
   input  logic [data_w-1:0]     wdata,
   input  logic [mem_addr_w-1:0] raddr,
   output logic [data_w-1:0]     rdata
);

   logic [data_w-1:0] mem [2**mem_addr_w];

   // host side
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // scanner side, one cycle read latency
   always_ff @(posedge clk) begin
      rdata <= mem[raddr];  // old data on a same address write
   end

endmodule

// File: hw/tf_reg_decode.sv
`timescale 1ns/1ps

module tf_reg_decode (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              req,
   input  logic                              we,
   input  logic [tf_bus_pkg::bus_addr_w-1:0] addr,
   input  logic [tf_bus_pkg::bus_data_w-1:0] wdata,
   input  logic                              done,
   input  logic [tf_flag_pkg::count_w-1:0]   match_count,
   output logic                              ack,
   output logic [tf_bus_pkg::bus_data_w-1:0] rdata,
   output logic                              pat_we,
   output logic [tf_bus_pkg::pat_addr_w-1:0] pat_waddr,
   output logic [tf_bus_pkg::bus_data_w-1:0] pat_wdata,
   output logic [tf_flag_pkg::count_w-1:0]   amount,
   output logic [tf_flag_pkg::count_w-1:0]   delay0,
   output logic                              disabled,
   output logic                              run
);
   import tf_bus_pkg::*;
   import tf_flag_pkg::*;

   logic access;
   logic reg_wr;

   assign access = req && !ack;  // one access per req rising
   assign reg_wr = access && we && (addr < pat_base);

   // pattern writes go straight through on the access edge
   assign pat_we    = access && we && (addr >= pat_base);
   assign pat_waddr = addr[pat_addr_w-1:0];
   assign pat_wdata = wdata;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ack <= 1'b0;
      end else if (access) begin
         ack <= 1'b1;
      end else if (!req) begin
         ack <= 1'b0;  // release once host drops req
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         amount   <= '0;
         delay0   <= '0;
         disabled <= 1'b0;
         run      <= 1'b0;
      end else begin
         run <= reg_wr && (addr == reg_ctrl) && wdata[0];  // self clearing
         if (reg_wr) begin
            case (addr)
               reg_amount: amount <= count_w'(wdata);
               reg_delay:  delay0 <= count_w'(wdata);
               reg_ctrl:   disabled <= wdata[1];
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access && !we) begin
         case (addr)
            reg_amount: rdata <= bus_data_w'(amount);
            reg_delay:  rdata <= bus_data_w'(delay0);
            reg_ctrl:   rdata <= bus_data_w'({disabled, 1'b0});  // run reads as 0
            reg_status: rdata <= bus_data_w'(done);
            reg_count:  rdata <= bus_data_w'(match_count);
            default:    rdata <= '0;  // pattern memory is write only
         endcase
      end
   end

   // ack only comes up in answer to a request
   a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
      $rose(ack) |-> $past(req));

endmodule

// File: hw/timed_flag_top.sv
`timescale 1ns/1ps

module timed_flag_top #(
   parameter int data_w     = tf_flag_pkg::flag_data_w,
   parameter int mem_addr_w = tf_bus_pkg::pat_addr_w
) (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              req,
   input  logic                              we,
   input  logic [tf_bus_pkg::bus_addr_w-1:0] addr,
   input  logic [tf_bus_pkg::bus_data_w-1:0] wdata,
   output logic                              ack,
   output logic [tf_bus_pkg::bus_data_w-1:0] rdata,
   input  logic                              in_valid,
   input  logic [data_w-1:0]                 in_data,
   output logic                              match,
   output logic                              done_req,
   input  logic                              done_ack,
   output logic [tf_flag_pkg::count_w-1:0]   done_cycles
);
   import tf_flag_pkg::*;

   logic                  pat_we;
   logic [mem_addr_w-1:0] pat_waddr;
   logic [data_w-1:0]     pat_wdata;
   logic [mem_addr_w-1:0] rd_addr;
   logic [data_w-1:0]     current_value;
   logic [count_w-1:0]    amount;
   logic [count_w-1:0]    delay0;
   logic [count_w-1:0]    match_count;
   logic                  disabled;
   logic                  run;
   logic                  done;
   logic                  advance;
   logic                  wait_busy;

   tf_reg_decode tf_reg_decode_i (
      .clk        (clk),
      .rst        (rst),
      .req        (req),
      .we         (we),
      .addr       (addr),
      .wdata      (wdata),
      .done       (done),
      .match_count(match_count),
      .ack        (ack),
      .rdata      (rdata),
      .pat_we     (pat_we),
      .pat_waddr  (pat_waddr),
      .pat_wdata  (pat_wdata),
      .amount     (amount),
      .delay0     (delay0),
      .disabled   (disabled),
      .run        (run)
   );

   tf_pattern_ram #(
      .data_w    (data_w),
      .mem_addr_w(mem_addr_w)
   ) tf_pattern_ram_i (
      .clk  (clk),
      .we   (pat_we),
      .waddr(pat_waddr),
      .wdata(pat_wdata),
      .raddr(rd_addr),
      .rdata(current_value)
   );

   tf_memory_scanner #(
      .mem_addr_w(mem_addr_w)
   ) tf_memory_scanner_i (
      .clk      (clk),
      .rst      (rst),
      .restart  (run),
      .advance  (advance),
      .rd_addr  (rd_addr),
      .wait_busy(wait_busy)
   );

   tf_match_exec #(
      .data_w(data_w)
   ) tf_match_exec_i (
      .clk          (clk),
      .rst          (rst),
      .run          (run),
      .disabled     (disabled),
      .amount       (amount),
      .delay0       (delay0),
      .in_valid     (in_valid),
      .in_data      (in_data),
      .current_value(current_value),
      .wait_busy    (wait_busy),
      .advance      (advance),
      .match        (match),
      .done         (done),
      .match_count  (match_count)
   );

   tf_done_report tf_done_report_i (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .done       (done),
      .done_ack   (done_ack),
      .done_req   (done_req),
      .done_cycles(done_cycles)
   );

endmodule

// File: timed_flag_top.f
hw/tf_bus_pkg.sv
hw/tf_flag_pkg.sv
hw/tf_reg_decode.sv
hw/tf_pattern_ram.sv
hw/tf_memory_scanner.sv
hw/tf_match_exec.sv
hw/tf_done_report.sv
hw/timed_flag_top.sv
dv/tf_tb.sv
